/* hw/raster_pkg.sv */
`default_nettype none

package raster_pkg;

  // pixel coordinates, enough for a 1024 x 1024 framebuffer
  localparam int COORD_W = 10;

  // depth is 0.16 fixed point
  localparam int DEPTH_W = 16;

  localparam int EDGE_W = 22;  // product of two coordinate differences, plus sign
  localparam int INV_FRAC = 30;  // fractional bits of the inverse area
  localparam int INV_W = 32;
  localparam int WSUM_W = 40;  // weight * depth summed over three vertices

  // one quotient bit per iteration, bits 30 down to 0
  localparam int DIV_CYCLES = 31;

  // dividend of the reciprocal, 1.0 in the inverse area's format
  localparam logic [DIV_CYCLES-1:0] DIV_NUMER = DIV_CYCLES'(1) << INV_FRAC;

  typedef logic [COORD_W-1:0] coord_t;
  typedef logic [DEPTH_W-1:0] depth_t;
  typedef logic signed [EDGE_W-1:0] edge_t;  // edge functions, steps and doubled area
  typedef logic [INV_W-1:0] inv_t;  // floor(2^30 / area2)
  typedef logic signed [WSUM_W-1:0] wsum_t;

endpackage

`default_nettype wire

/* hw/recip_div.sv */
`timescale 1ns/1ps
`default_nettype none

// restoring divider, quotient = floor(2^30 / divisor) for divisor > 0
module recip_div (
  input wire clk_in,
  input wire rst_in,
  input wire start,
  input wire raster_pkg::edge_t divisor,
  output logic done,
  output raster_pkg::inv_t quotient
);
  import raster_pkg::*;

  localparam int CNT_W = $clog2(DIV_CYCLES);

  logic busy;
  logic [CNT_W-1:0] iter;
  logic [DIV_CYCLES-1:0] numer;  // dividend, shifted out msb first
  logic [EDGE_W-1:0] denom;
  logic [EDGE_W-1:0] rem;  // always below denom
  logic [EDGE_W:0] trial;
  logic fits;

  assign trial = {rem, numer[DIV_CYCLES-1]};
  assign fits = trial >= {1'b0, denom};

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= 1'b0;
      iter <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        iter <= '0;
      end else if (busy) begin
        iter <= iter + 1'b1;
        if (iter == CNT_W'(DIV_CYCLES - 1)) begin  // last quotient bit this cycle
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (start) begin
      numer <= DIV_NUMER;
      denom <= $unsigned(divisor);
      rem <= '0;
      quotient <= '0;
    end else if (busy) begin
      numer <= {numer[DIV_CYCLES-2:0], 1'b0};
      // subtract only when the shifted remainder covers the divisor
      rem <= fits ? EDGE_W'(trial - {1'b0, denom}) : trial[EDGE_W-1:0];
      quotient <= {quotient[INV_W-2:0], fits};
    end
  end

endmodule

`default_nettype wire

/* hw/tri_setup.sv */
`timescale 1ns/1ps
`default_nettype none

module tri_setup #(
  parameter int FB_HRES = 320,
  parameter int FB_VRES = 180
) (
  input wire clk_in,
  input wire rst_in,
  input wire valid_in,
  output logic ready_out,
  input wire raster_pkg::coord_t [2:0] x_in,
  input wire raster_pkg::coord_t [2:0] y_in,
  input wire raster_pkg::depth_t [2:0] z_in,
  output logic setup_valid,
  input wire setup_taken,
  output raster_pkg::coord_t h_min,
  output raster_pkg::coord_t h_max,
  output raster_pkg::coord_t v_min,
  output raster_pkg::coord_t v_max,
  output raster_pkg::edge_t e0,
  output raster_pkg::edge_t e1,
  output raster_pkg::edge_t e2,
  output raster_pkg::edge_t dx0,
  output raster_pkg::edge_t dx1,
  output raster_pkg::edge_t dx2,
  output raster_pkg::edge_t dy0,
  output raster_pkg::edge_t dy1,
  output raster_pkg::edge_t dy2,
  output raster_pkg::depth_t z0,
  output raster_pkg::depth_t z1,
  output raster_pkg::depth_t z2,
  output raster_pkg::inv_t inv_area
);
  import raster_pkg::*;

  localparam coord_t H_LAST = coord_t'(FB_HRES - 1);
  localparam coord_t V_LAST = coord_t'(FB_VRES - 1);

  typedef enum logic [2:0] {IDLE, BBOX, DIVIDE, HOLD, BUSY} state_t;
  state_t state;

  coord_t [2:0] xv;
  coord_t [2:0] yv;
  depth_t [2:0] zv;
  coord_t x_lo, x_hi, y_lo, y_hi;
  edge_t area2;
  logic reject;
  logic div_start;
  logic div_done;
  inv_t div_q;

  function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
    coord_t m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
    coord_t m;
    m = (a > b) ? a : b;
    return (m > c) ? m : c;
  endfunction

  function automatic logic signed [11:0] cdiff(input coord_t a, input coord_t b);
    return $signed({2'b00, a}) - $signed({2'b00, b});
  endfunction

  // edge a->b evaluated at (h, v)
  function automatic edge_t edge_fn(input coord_t ax, input coord_t ay, input coord_t bx,
                                    input coord_t by, input coord_t h, input coord_t v);
    logic signed [23:0] p;
    logic signed [23:0] q;
    p = cdiff(bx, ax) * cdiff(v, ay);
    q = cdiff(by, ay) * cdiff(h, ax);
    return edge_t'(p - q);
  endfunction

  always_comb begin
    x_lo = min3(xv[0], xv[1], xv[2]);
    x_hi = max3(xv[0], xv[1], xv[2]);
    y_lo = min3(yv[0], yv[1], yv[2]);
    y_hi = max3(yv[0], yv[1], yv[2]);
    area2 = edge_fn(xv[0], yv[0], xv[1], yv[1], xv[2], yv[2]);
    // back-facing, degenerate, or wholly right of / below the framebuffer
    reject = (area2 <= 0) || (x_lo > H_LAST) || (y_lo > V_LAST);
  end

  assign ready_out = state == IDLE;
  assign setup_valid = state == HOLD;
  assign div_start = (state == BBOX) && !reject;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (valid_in) state <= BBOX;
        BBOX:    state <= reject ? IDLE : DIVIDE;
        DIVIDE:  if (div_done) state <= HOLD;
        HOLD:    state <= BUSY;  // walker loads in this cycle
        BUSY:    if (setup_taken) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (ready_out && valid_in) begin
      xv <= x_in;
      yv <= y_in;
      zv <= z_in;
    end
    if (state == BBOX) begin
      h_min <= x_lo;
      v_min <= y_lo;
      h_max <= (x_hi > H_LAST) ? H_LAST : x_hi;
      v_max <= (y_hi > V_LAST) ? V_LAST : y_hi;
      e0 <= edge_fn(xv[1], yv[1], xv[2], yv[2], x_lo, y_lo);  // edge v1->v2
      e1 <= edge_fn(xv[2], yv[2], xv[0], yv[0], x_lo, y_lo);  // edge v2->v0
      e2 <= edge_fn(xv[0], yv[0], xv[1], yv[1], x_lo, y_lo);  // edge v0->v1
      dx0 <= cdiff(yv[1], yv[2]);
      dx1 <= cdiff(yv[2], yv[0]);
      dx2 <= cdiff(yv[0], yv[1]);
      dy0 <= cdiff(xv[2], xv[1]);
      dy1 <= cdiff(xv[0], xv[2]);
      dy2 <= cdiff(xv[1], xv[0]);
    end
    if (div_done) inv_area <= div_q;
  end

  assign z0 = zv[0];
  assign z1 = zv[1];
  assign z2 = zv[2];

  recip_div u_recip_div (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .start(div_start),
    .divisor(area2),
    .done(div_done),
    .quotient(div_q)
  );

endmodule

`default_nettype wire

/* hw/pixel_walker.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_walker (
  input wire clk_in,
  input wire rst_in,
  input wire setup_valid,
  output logic setup_taken,
  input wire raster_pkg::coord_t h_min,
  input wire raster_pkg::coord_t h_max,
  input wire raster_pkg::coord_t v_min,
  input wire raster_pkg::coord_t v_max,
  input wire raster_pkg::edge_t e0,
  input wire raster_pkg::edge_t e1,
  input wire raster_pkg::edge_t e2,
  input wire raster_pkg::edge_t dx0,
  input wire raster_pkg::edge_t dx1,
  input wire raster_pkg::edge_t dx2,
  input wire raster_pkg::edge_t dy0,
  input wire raster_pkg::edge_t dy1,
  input wire raster_pkg::edge_t dy2,
  input wire raster_pkg::depth_t z0,
  input wire raster_pkg::depth_t z1,
  input wire raster_pkg::depth_t z2,
  input wire raster_pkg::inv_t inv_area,
  output logic pix_valid,
  input wire pix_ready,
  output raster_pkg::coord_t pix_h,
  output raster_pkg::coord_t pix_v,
  output raster_pkg::edge_t pix_w0,
  output raster_pkg::edge_t pix_w1,
  output raster_pkg::edge_t pix_w2,
  output raster_pkg::depth_t pix_z0,
  output raster_pkg::depth_t pix_z1,
  output raster_pkg::depth_t pix_z2,
  output raster_pkg::inv_t pix_inv
);
  import raster_pkg::*;

  logic active;
  logic load;
  logic advance;
  logic covered;
  logic row_end;
  logic box_end;
  coord_t h, v;
  edge_t acc0, acc1, acc2;  // edge values at (h, v)
  edge_t row0, row1, row2;  // edge values at the start of the current row

  assign load = setup_valid && !active;
  assign advance = active && pix_ready;  // hold the current pixel under back-pressure
  assign covered = (acc0 >= 0) && (acc1 >= 0) && (acc2 >= 0);
  assign row_end = h == h_max;
  assign box_end = row_end && (v == v_max);

  assign pix_valid = active && covered;
  assign setup_taken = advance && box_end;  // last box pixel leaves this cycle

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      active <= 1'b0;
    end else if (load) begin
      active <= 1'b1;
    end else if (setup_taken) begin
      active <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (load) begin
      h <= h_min;
      v <= v_min;
      acc0 <= e0;
      acc1 <= e1;
      acc2 <= e2;
      row0 <= e0;
      row1 <= e1;
      row2 <= e2;
    end else if (advance) begin
      if (row_end) begin
        // next row starts one row step below the previous row start
        h <= h_min;
        v <= v + 1'b1;
        row0 <= row0 + dy0;
        row1 <= row1 + dy1;
        row2 <= row2 + dy2;
        acc0 <= row0 + dy0;
        acc1 <= row1 + dy1;
        acc2 <= row2 + dy2;
      end else begin
        h <= h + 1'b1;
        acc0 <= acc0 + dx0;
        acc1 <= acc1 + dx1;
        acc2 <= acc2 + dx2;
      end
    end
  end

  assign pix_h = h;
  assign pix_v = v;
  assign pix_w0 = acc0;
  assign pix_w1 = acc1;
  assign pix_w2 = acc2;
  assign pix_z0 = z0;  // setup holds these until the box is done
  assign pix_z1 = z1;
  assign pix_z2 = z2;
  assign pix_inv = inv_area;

endmodule

`default_nettype wire

/* hw/depth_interp.sv */
`timescale 1ns/1ps
`default_nettype none

// three stage pipeline: products, sum, scale by the inverse area
module depth_interp (
  input wire clk_in,
  input wire rst_in,
  input wire pix_valid,
  output logic pix_ready,
  input wire raster_pkg::coord_t pix_h,
  input wire raster_pkg::coord_t pix_v,
  input wire raster_pkg::edge_t pix_w0,
  input wire raster_pkg::edge_t pix_w1,
  input wire raster_pkg::edge_t pix_w2,
  input wire raster_pkg::depth_t pix_z0,
  input wire raster_pkg::depth_t pix_z1,
  input wire raster_pkg::depth_t pix_z2,
  input wire raster_pkg::inv_t pix_inv,
  output logic valid_out,
  input wire ready_in,
  output raster_pkg::coord_t hcount_out,
  output raster_pkg::coord_t vcount_out,
  output raster_pkg::depth_t z_out
);
  import raster_pkg::*;

  logic s1_valid, s2_valid;
  logic s1_ready, s2_ready, s3_ready;
  coord_t s1_h, s1_v;
  coord_t s2_h, s2_v;
  wsum_t s1_p0, s1_p1, s1_p2;
  wsum_t s2_sum;
  inv_t s1_inv, s2_inv;
  logic [WSUM_W+INV_W-1:0] scaled;

  // a stage takes new data when it is empty or its content moves on
  assign s3_ready = !valid_out || ready_in;
  assign s2_ready = !s2_valid || s3_ready;
  assign s1_ready = !s1_valid || s2_ready;
  assign pix_ready = s1_ready;

  // weights of a covered pixel are non-negative, so the sum is too
  assign scaled = $unsigned(s2_sum) * s2_inv;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      if (s1_ready) s1_valid <= pix_valid;
      if (s2_ready) s2_valid <= s1_valid;
      if (s3_ready) valid_out <= s2_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (s1_ready && pix_valid) begin
      s1_h <= pix_h;
      s1_v <= pix_v;
      s1_p0 <= pix_w0 * $signed({1'b0, pix_z0});
      s1_p1 <= pix_w1 * $signed({1'b0, pix_z1});
      s1_p2 <= pix_w2 * $signed({1'b0, pix_z2});
      s1_inv <= pix_inv;  // travels along, setup may move to the next triangle
    end
    if (s2_ready && s1_valid) begin
      s2_h <= s1_h;
      s2_v <= s1_v;
      s2_sum <= s1_p0 + s1_p1 + s1_p2;
      s2_inv <= s1_inv;
    end
    if (s3_ready && s2_valid) begin
      hcount_out <= s2_h;
      vcount_out <= s2_v;
      z_out <= scaled[INV_FRAC +: DEPTH_W];  // floor by 2^30, keep 16 bits
    end
  end

endmodule

`default_nettype wire

/* hw/rasterizer.sv */
`timescale 1ns/1ps
`default_nettype none

module rasterizer #(
  parameter int FB_HRES = 320,
  parameter int FB_VRES = 180
) (
  input wire clk_in,
  input wire rst_in,
  input wire valid_in,
  output logic ready_out,
  input wire raster_pkg::coord_t [2:0] x_in,
  input wire raster_pkg::coord_t [2:0] y_in,
  input wire raster_pkg::depth_t [2:0] z_in,
  output logic valid_out,
  input wire ready_in,
  output raster_pkg::coord_t hcount_out,
  output raster_pkg::coord_t vcount_out,
  output raster_pkg::depth_t z_out
);
  import raster_pkg::*;

  // setup to walker, held until the walker finishes the box
  logic setup_valid;
  logic setup_taken;
  coord_t h_min, h_max, v_min, v_max;
  edge_t e0, e1, e2;
  edge_t dx0, dx1, dx2;
  edge_t dy0, dy1, dy2;
  depth_t z0, z1, z2;
  inv_t inv_area;

  // walker to interpolator, one covered pixel per beat
  logic pix_valid;
  logic pix_ready;
  coord_t pix_h, pix_v;
  edge_t pix_w0, pix_w1, pix_w2;
  depth_t pix_z0, pix_z1, pix_z2;
  inv_t pix_inv;

  tri_setup #(
    .FB_HRES(FB_HRES),
    .FB_VRES(FB_VRES)
  ) u_tri_setup (.*);  // ready_out is high only while setup is idle

  pixel_walker u_pixel_walker (.*);

  depth_interp u_depth_interp (.*);

endmodule

`default_nettype wire

/* tests/tb_rasterizer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rasterizer;
  import raster_pkg::*;

  localparam int MAX_TRI = 32;
  localparam int SEED = 32'h53b3_8291;
  localparam string DATA_FILE = "tests/raster_input.txt";

  logic clk_in;
  logic rst_in;
  logic valid_in;
  logic ready_out;
  coord_t [2:0] x_in;
  coord_t [2:0] y_in;
  depth_t [2:0] z_in;
  logic valid_out;
  logic ready_in;
  coord_t hcount_out;
  coord_t vcount_out;
  depth_t z_out;

  // triangles from the data file
  int tri_x [MAX_TRI][3];
  int tri_y [MAX_TRI][3];
  int tri_z [MAX_TRI][3];
  int tri_mode [MAX_TRI];
  int tri_count [MAX_TRI];
  int n_tri = 0;
  int hdr_tri = 0;
  int hdr_pix = 0;
  int hdr_box = 0;

  // expected beats in output order and the triangle each one belongs to
  int exp_h [$];
  int exp_v [$];
  int exp_z [$];
  int exp_tri [$];

  int cur_mode = 0;  // ready_in mode of the latest accepted triangle
  int cycles = 0;
  int cycle_limit = 0;

  rasterizer u_rasterizer (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(valid_in),
    .ready_out(ready_out),
    .x_in(x_in),
    .y_in(y_in),
    .z_in(z_in),
    .valid_out(valid_out),
    .ready_in(ready_in),
    .hcount_out(hcount_out),
    .vcount_out(vcount_out),
    .z_out(z_out)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input int got, input int expected);
    if (got != expected) begin
      stop_run($sformatf("Fail at %0d ns: %s is %0d, expected %0d", $time, name, got,
                         expected));
    end
  endtask

  task automatic read_stimulus();
    int fd;
    int c;
    int n;
    int h, v, z;
    int done;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) stop_run("cannot open the data file tests/raster_input.txt");
    done = 0;
    while (done == 0) begin
      c = $fgetc(fd);
      if (c == -1) begin
        done = 1;
      end else if (c == "#") begin
        while (c != "\n" && c != -1) c = $fgetc(fd);  // skip comment line
      end else if (c == "H") begin
        n = $fscanf(fd, "%d %d %d", hdr_tri, hdr_pix, hdr_box);
        if (n != 3) stop_run("the header line of the data file is malformed");
      end else if (c == "T") begin
        if (n_tri == MAX_TRI) stop_run("the data file holds too many triangles");
        n = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d",
                    tri_x[n_tri][0], tri_y[n_tri][0], tri_x[n_tri][1], tri_y[n_tri][1],
                    tri_x[n_tri][2], tri_y[n_tri][2], tri_z[n_tri][0], tri_z[n_tri][1],
                    tri_z[n_tri][2], tri_mode[n_tri], tri_count[n_tri]);
        if (n != 11) stop_run("a triangle line of the data file is malformed");
        n_tri++;
      end else if (c == "P") begin
        if (n_tri == 0) stop_run("a pixel line comes before the first triangle");
        n = $fscanf(fd, "%d %d %d", h, v, z);
        if (n != 3) stop_run("a pixel line of the data file is malformed");
        exp_h.push_back(h);
        exp_v.push_back(v);
        exp_z.push_back(z);
        exp_tri.push_back(n_tri - 1);
      end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
        stop_run("the data file holds an unknown record");
      end
    end
    $fclose(fd);
  endtask

  task automatic present_triangle(input int k);
    int i;
    for (i = 0; i < 3; i++) begin
      x_in[i] = coord_t'(tri_x[k][i]);
      y_in[i] = coord_t'(tri_y[k][i]);
      z_in[i] = depth_t'(tri_z[k][i]);
    end
    valid_in = 1'b1;
  endtask

  initial begin
    clk_in = 1'b0;
    forever #4 clk_in = ~clk_in;
  end

  // ready_in is random only for triangles with mode 1
  initial begin
    ready_in = 1'b0;
    void'($urandom(SEED));
    forever begin
      @(posedge clk_in);
      #1;
      if (cur_mode == 0) ready_in = 1'b1;
      else ready_in = 1'($urandom % 2);
    end
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles > cycle_limit) begin
      stop_run($sformatf("timeout: the run did not finish within %0d clock cycles",
                         cycle_limit));
    end
  end

  // outputs settle by the falling edge and transfer on the next rising one
  always @(negedge clk_in) begin
    if (!rst_in && valid_out && ready_in) begin
      if (exp_h.size() == 0) begin
        stop_run("an output beat arrived after every expected pixel was seen");
      end else begin
        check_value("hcount_out", hcount_out, exp_h[0]);
        check_value("vcount_out", vcount_out, exp_v[0]);
        check_value("z_out", z_out, exp_z[0]);
        void'(exp_h.pop_front());
        void'(exp_v.pop_front());
        void'(exp_z.pop_front());
      end
    end
  end

  initial begin
    int k;
    int listed;
    rst_in = 1'b1;
    valid_in = 1'b0;
    x_in = '0;
    y_in = '0;
    z_in = '0;
    read_stimulus();
    check_value("triangles in the data file", n_tri, hdr_tri);
    check_value("pixels in the data file", exp_h.size(), hdr_pix);
    for (k = 0; k < n_tri; k++) begin
      listed = 0;
      foreach (exp_tri[i]) if (exp_tri[i] == k) listed++;
      check_value($sformatf("pixel lines of triangle %0d", k), listed, tri_count[k]);
    end
    cycle_limit = 4 * (hdr_pix + 40 * hdr_tri + hdr_box);

    repeat (8) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    @(negedge clk_in);
    check_value("valid_out", valid_out, 0);  // idle after reset
    check_value("ready_out", ready_out, 1);

    @(posedge clk_in);
    #1;
    if (n_tri > 0) present_triangle(0);
    @(negedge clk_in);
    for (k = 0; k < n_tri; k++) begin
      while (!ready_out) @(negedge clk_in);
      @(posedge clk_in);  // triangle k taken on this edge
      cur_mode = tri_mode[k];
      #1;
      // next triangle waits on valid_in while the machine is busy
      if (k + 1 < n_tri) present_triangle(k + 1);
      else valid_in = 1'b0;
      @(negedge clk_in);
      check_value("ready_out", ready_out, 0);
      if (tri_count[k] == 0) begin
        @(negedge clk_in);
        check_value("ready_out", ready_out, 1);  // rejected after the box cycle
      end
    end

    while (exp_h.size() > 0) @(negedge clk_in);
    repeat (20) @(negedge clk_in);  // the monitor catches any extra beat in this window
    check_value("ready_out", ready_out, 1);
    check_value("valid_out", valid_out, 0);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* rasterizer.f */
hw/raster_pkg.sv
hw/recip_div.sv
hw/tri_setup.sv
hw/pixel_walker.sv
hw/depth_interp.sv
hw/rasterizer.sv
tests/tb_rasterizer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal -j 0
TOP = tb_rasterizer
FILELIST = rasterizer.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

# the run passes only if the log holds the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/raster_input.txt */
# H triangles total_pixels box_area_sum
# T x0 y0 x1 y1 x2 y2 z0 z1 z2 ready_mode pixel_count, then P h v z per covered pixel
H 6 23 164
T 10 20 12 20 10 22 1000 2000 3001 0 6
P 10 20 1000
P 11 20 1500
P 12 20 2000
P 10 21 2000
P 11 21 2500
P 10 22 3001
T 100 50 103 50 100 52 600 1200 6001 1 7
P 100 50 599
P 101 50 799
P 102 50 999
P 103 50 1199
P 100 51 3300
P 101 51 3500
P 100 52 6000
T 5 5 10 10 15 15 100 200 300 0 0
T 10 20 10 22 12 20 1000 2000 3001 0 0
T 318 178 322 178 318 182 40000 40400 48002 1 4
P 318 178 40000
P 319 178 40100
P 318 179 42000
P 319 179 42100
T 0 0 2 0 0 2 65535 0 1 1 6
P 0 0 65535
P 1 0 32767
P 2 0 0
P 0 1 32768
P 1 1 0
P 0 2 1
